// ==== all.f ====
hdl/lsu_pkg.sv
hdl/dcache_pkg.sv
hdl/ld_ctrl.sv
hdl/ld_req_format.sv
hdl/ld_retire.sv
hdl/load_unit.sv
bench/load_unit_properties.sv
bench/load_unit_tb.sv

// ==== bench/load_unit_properties.sv ====
`timescale 1ns/1ps

module load_unit_properties
    import dcache_pkg::*;
(
    input logic    clk_i,
    input logic    rst_ni,
    input logic    dc_req_valid_o,
    input logic    dc_gnt_i,
    input dc_req_t dc_req_o,
    input logic    dtlb_hit_i,
    input dc_tag_t dc_tag_o
);

    // ------------------------------------------------------------------------
    // cache request handshake
    // ------------------------------------------------------------------------

    // a request that waits for the grant must not change under the cache
    // it may only be withdrawn, which a flush does
    req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (dc_req_valid_o && !dc_gnt_i) |=> (!dc_req_valid_o || $stable(dc_req_o)))
        else $error("cache request changed while waiting for the grant");

    // a granted request with a valid translation sends its tag right after
    tag_follows_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (dc_req_valid_o && dc_gnt_i && dtlb_hit_i) |=> dc_tag_o.tag_valid)
        else $error("no tag phase after a granted request with a TLB hit");

    // ------------------------------------------------------------------------
    // tag phase
    // ------------------------------------------------------------------------

    // the cache only looks at kill in a tag phase
    kill_with_tag_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dc_tag_o.kill |-> dc_tag_o.tag_valid)
        else $error("kill raised without tag_valid");

endmodule

bind load_unit load_unit_properties props0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .dc_req_valid_o (dc_req_valid_o),
    .dc_gnt_i       (dc_gnt_i),
    .dc_req_o       (dc_req_o),
    .dtlb_hit_i     (dtlb_hit_i),
    .dc_tag_o       (dc_tag_o)
);

// ==== bench/load_unit_tb.sv ====
`timescale 1ns/1ps

module load_unit_tb
    import lsu_pkg::*, dcache_pkg::*;
;

    localparam int CLK_PERIOD   = 4;

    // number of loads each test issues
    // all_ops covers 8 + 8 + 4 + 4 + 2 + 2 + 1 aligned offsets of the seven operators
    localparam int N_ALL_OPS    = 29;
    localparam int N_RANDOM     = 40;
    localparam int N_HAZARD     = 3;
    localparam int N_MISS       = 2;
    localparam int N_FLUSH      = 2;
    localparam int N_B2B        = 8;
    localparam int TOTAL_LOADS  = N_ALL_OPS + N_RANDOM + N_HAZARD + N_MISS + N_FLUSH + N_B2B;

    // grant wait, store hazard, TLB walk and draining together stay below this
    localparam int WORST_CYCLES = 20;

    logic clk_i, rst_ni, flush_i, valid_i, pop_o;
    ld_req_t req_i;
    logic translation_req_o, dtlb_hit_i, page_offset_match_i;
    logic [XLEN-1:0] vaddr_o;
    logic [PLEN-1:0] paddr_i;
    logic [PAGE_OFFSET_W-1:0] page_offset_o;
    logic dc_req_valid_o, dc_gnt_i, dc_rvalid_i, res_valid_o;
    dc_req_t dc_req_o;
    dc_tag_t dc_tag_o;
    logic [XLEN-1:0] dc_rdata_i, res_data_o;
    logic [TRANS_ID_W-1:0] res_trans_id_o;

    logic [XLEN-1:0] mem [512];
    logic [TRANS_ID_W-1:0] exp_tid[$];
    logic [XLEN-1:0] exp_data[$];
    int exp_cycle[$];
    logic [DC_INDEX_W-1:0] pend_idx;
    logic [TRANS_ID_W-1:0] next_tid;
    int gnt_wait, cycle_cnt, errors, tests, test_start;
    int tag_cnt, kill_cnt, pop_cnt, overlap_cnt;
    bit grant_random, strict_timing;
    string cur_test;

    load_unit dut0 (.*);

    // the TLB maps every page onto itself
    assign paddr_i = req_i.vaddr[PLEN-1:0];

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle_cnt++;

    // ------------------------------------------------------------------------
    // reference model of a load
    // ------------------------------------------------------------------------
    function automatic logic [63:0] expected_load(ld_op_e op, logic [2:0] off,
                                                  logic [63:0] w);
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] x;
        b = w[8*off +: 8];
        h = w[8*off +: 16];
        x = w[8*off +: 32];
        case (op)
            LB:      return {{56{b[7]}}, b};
            LBU:     return {56'h0, b};
            LH:      return {{48{h[15]}}, h};
            LHU:     return {48'h0, h};
            LW:      return {{32{x[31]}}, x};
            LWU:     return {32'h0, x};
            default: return w;
        endcase
    endfunction

    function automatic int op_bytes(ld_op_e op);
        case (op)
            LB, LBU: return 1;
            LH, LHU: return 2;
            LW, LWU: return 4;
            default: return 8;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // cache model
    // ------------------------------------------------------------------------

    // answers every tag phase that is not a kill with the word at the index
    always @(posedge clk_i) begin
        #1;
        dc_gnt_i    = (gnt_wait == 0);
        dc_rvalid_i = dc_tag_o.tag_valid && !dc_tag_o.kill;
        dc_rdata_i  = dc_rvalid_i ? mem[pend_idx[11:3]] : 64'h0;
    end

    // request acceptance and tag phases are observed in the middle of the cycle
    always @(negedge clk_i) begin
        if (dc_req_valid_o && dc_gnt_i) begin
            pend_idx = dc_req_o.index;
            gnt_wait = grant_random ? int'($urandom_range(0, 3)) : 0;
        end else if (dc_req_valid_o && gnt_wait > 0) begin
            gnt_wait--;
        end
        if (dc_tag_o.tag_valid && dc_tag_o.kill) kill_cnt++;
        if (dc_tag_o.tag_valid && !dc_tag_o.kill) tag_cnt++;
        if (pop_o) pop_cnt++;
        if (pop_o && dc_tag_o.tag_valid && !dc_tag_o.kill) overlap_cnt++;
    end

    // ------------------------------------------------------------------------
    // compare process
    // ------------------------------------------------------------------------
    always @(negedge clk_i) begin
        logic [TRANS_ID_W-1:0] t;
        logic [XLEN-1:0] d;
        int c;
        if (res_valid_o) begin
            if (exp_tid.size() == 0) begin
                errors++;
                $display("Error in %s: result with no load outstanding", cur_test);
            end else begin
                t = exp_tid.pop_front();
                d = exp_data.pop_front();
                c = exp_cycle.pop_front();
                if (res_trans_id_o !== t) begin
                    errors++;
                    $display("Mismatch in %s: trans_id expected %0d, actual %0d",
                             cur_test, t, res_trans_id_o);
                end
                if (res_data_o !== d) begin
                    errors++;
                    $display("Mismatch in %s: data expected %h, actual %h",
                             cur_test, d, res_data_o);
                end
                if (strict_timing && cycle_cnt != c) begin
                    errors++;
                    $display("Error in %s: load retired in cycle %0d, not in cycle %0d",
                             cur_test, cycle_cnt, c);
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // issue side, MMU and store buffer
    // ------------------------------------------------------------------------

    // the MMU and the store buffer see the address of the presented load
    // the cache request carries the untranslated index, one enable per
    // accessed byte shifted up by the offset, and log2 of the byte count
    task automatic check_request(ld_op_e op, logic [63:0] addr);
        logic [DC_BE_W-1:0] be;
        dc_size_e           size;
        be   = DC_BE_W'((1 << op_bytes(op)) - 1);
        be   = be << addr[2:0];
        size = dc_size_e'($clog2(op_bytes(op)));
        if (vaddr_o !== addr) begin
            errors++;
            $display("Mismatch in %s: vaddr expected %h, actual %h",
                     cur_test, addr, vaddr_o);
        end
        if (page_offset_o !== addr[PAGE_OFFSET_W-1:0]) begin
            errors++;
            $display("Mismatch in %s: page offset expected %h, actual %h",
                     cur_test, addr[PAGE_OFFSET_W-1:0], page_offset_o);
        end
        if (dc_req_valid_o) begin
            // the tag of a granted request needs a translation in the same cycle
            if (!translation_req_o) begin
                errors++;
                $display("Error in %s: cache request sent without a translation request",
                         cur_test);
            end
            if (dc_req_o.index !== addr[DC_INDEX_W-1:0]) begin
                errors++;
                $display("Mismatch in %s: index expected %h, actual %h",
                         cur_test, addr[DC_INDEX_W-1:0], dc_req_o.index);
            end
            if (dc_req_o.be !== be) begin
                errors++;
                $display("Mismatch in %s: byte enables expected %h, actual %h",
                         cur_test, be, dc_req_o.be);
            end
            if (dc_req_o.size !== size) begin
                errors++;
                $display("Mismatch in %s: size expected %0d, actual %0d",
                         cur_test, size, dc_req_o.size);
            end
        end
    endtask

    // presents one load until it is popped; stall holds the store hazard for
    // that many cycles and miss makes the TLB miss until the walk is done
    task automatic issue_load(ld_op_e op, logic [63:0] addr, int stall, bit miss);
        int walk_cnt;
        bit done;
        walk_cnt = 0;
        done     = 1'b0;
        while (!done) begin
            valid_i             = 1'b1;
            req_i.vaddr         = addr;
            req_i.op            = op;
            req_i.trans_id      = next_tid;
            page_offset_match_i = (stall > 0);
            dtlb_hit_i          = !miss;
            @(negedge clk_i);
            check_request(op, addr);
            if (page_offset_match_i && dc_req_valid_o) begin
                errors++;
                $display("Error in %s: cache request sent during a store hazard", cur_test);
            end
            if (dc_tag_o.tag_valid && dc_tag_o.kill) walk_cnt = 2;
            if (pop_o) begin
                exp_tid.push_back(next_tid);
                exp_data.push_back(expected_load(op, addr[2:0], mem[addr[11:3]]));
                exp_cycle.push_back(cycle_cnt + 1);
                next_tid++;
                done = 1'b1;
            end
            @(posedge clk_i);
            #1;
            if (stall > 0) stall--;
            if (walk_cnt > 0) begin
                walk_cnt--;
                if (walk_cnt == 0) miss = 1'b0;
            end
        end
        valid_i             = 1'b0;
        page_offset_match_i = 1'b0;
        dtlb_hit_i          = 1'b1;
    endtask

    function automatic logic [63:0] rand_addr(ld_op_e op);
        logic [63:0] a;
        a      = {$urandom, $urandom};
        a[2:0] = 3'($urandom_range(0, 7)) & ~3'(op_bytes(op) - 1);
        return a;
    endfunction

    // waits until every popped load has retired
    task automatic drain();
        int n;
        n = 0;
        while (exp_tid.size() > 0 && n < 50) begin
            @(negedge clk_i);
            n++;
        end
        if (exp_tid.size() > 0) begin
            errors++;
            $display("Error in %s: %0d loads never retired", cur_test, exp_tid.size());
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic begin_test(string name);
        cur_test   = name;
        test_start = errors;
        tests++;
    endtask

    task automatic end_test();
        $display("test %s: %s (%0d errors)", cur_test,
                 (errors == test_start) ? "ok" : "FAILED", errors - test_start);
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    initial begin
        ld_op_e op;
        logic [63:0] a;
        int pops;
        flush_i             = 1'b0;
        valid_i             = 1'b0;
        req_i               = '0;
        dtlb_hit_i          = 1'b1;
        page_offset_match_i = 1'b0;
        dc_gnt_i            = 1'b0;
        dc_rvalid_i         = 1'b0;
        dc_rdata_i          = '0;
        rst_ni              = 1'b0;
        gnt_wait            = 0;
        cycle_cnt           = 0;
        errors              = 0;
        tests               = 0;
        next_tid            = '0;
        void'($urandom(96302));
        for (int i = 0; i < 512; i++) mem[i] = {$urandom, $urandom};
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        // every operator at every aligned offset
        begin_test("all_ops");
        for (int o = 0; o < 7; o++) begin
            op = ld_op_e'(o);
            for (int off = 0; off < 8; off += op_bytes(op)) begin
                a      = rand_addr(op);
                a[2:0] = 3'(off);
                issue_load(op, a, 0, 1'b0);
            end
        end
        drain();
        end_test();

        begin_test("random_grants");
        grant_random = 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            op = ld_op_e'($urandom_range(0, 6));
            issue_load(op, rand_addr(op), 0, 1'b0);
        end
        drain();
        grant_random = 1'b0;
        end_test();

        begin_test("store_hazard");
        for (int i = 1; i <= N_HAZARD; i++) issue_load(LW, rand_addr(LW), i + 1, 1'b0);
        drain();
        end_test();

        // one kill tag phase and one real tag phase per missing load
        begin_test("tlb_miss");
        for (int i = 0; i < N_MISS; i++) begin
            tag_cnt  = 0;
            kill_cnt = 0;
            issue_load(LH, rand_addr(LH), 0, 1'b1);
            drain();
            if (kill_cnt != 1 || tag_cnt != 1) begin
                errors++;
                $display("Error in %s: saw %0d kill and %0d normal tag phases",
                         cur_test, kill_cnt, tag_cnt);
            end
        end
        end_test();

        // the load stalls on a hazard and is flushed before it is popped
        begin_test("flush");
        pops                = pop_cnt;
        valid_i             = 1'b1;
        req_i.vaddr         = rand_addr(LD);
        req_i.op            = LD;
        page_offset_match_i = 1'b1;
        @(posedge clk_i);
        #1;
        flush_i             = 1'b1;
        valid_i             = 1'b0;
        page_offset_match_i = 1'b0;
        @(posedge clk_i);
        #1;
        flush_i = 1'b0;
        repeat (3) @(posedge clk_i);
        #1;
        if (pop_cnt != pops) begin
            errors++;
            $display("Error in %s: the flushed load was popped", cur_test);
        end
        issue_load(LBU, rand_addr(LBU), 0, 1'b0);
        drain();
        end_test();

        begin_test("back_to_back");
        strict_timing = 1'b1;
        overlap_cnt   = 0;
        for (int i = 0; i < N_B2B; i++) begin
            op = ld_op_e'(i % 7);
            issue_load(op, rand_addr(op), 0, 1'b0);
        end
        drain();
        strict_timing = 1'b0;
        if (overlap_cnt == 0) begin
            errors++;
            $display("Error in %s: never had two loads in flight", cur_test);
        end
        end_test();

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog sized by the number of loads and the slowest load
    initial begin
        #(TOTAL_LOADS * WORST_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== hdl/dcache_pkg.sv ====
package dcache_pkg;

    // the tag phase carries a physical tag of the load path width
    import lsu_pkg::*;

    // ------------------------------------------------------------------------
    // data cache port
    // ------------------------------------------------------------------------

    // the index addresses the set, it is the untranslated page offset
    localparam int unsigned DC_INDEX_W = PAGE_OFFSET_W;

    // one enable per byte of the 64-bit data word
    localparam int unsigned DC_BE_W = XLEN / 8;

    // transfer size, encoded as log2 of the number of bytes
    typedef enum logic [1:0] {
        BYTE  = 2'd0,
        HALF  = 2'd1,
        WORD  = 2'd2,
        DWORD = 2'd3
    } dc_size_e;

    // request phase, held until the cache grants it
    typedef struct packed {
        logic [DC_INDEX_W-1:0] index;
        logic [DC_BE_W-1:0]    be;
        dc_size_e              size;
    } dc_req_t;

    // tag phase, one cycle after the grant
    // kill together with tag_valid aborts the request that was granted
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             tag_valid;
        logic             kill;
    } dc_tag_t;

endpackage

// ==== hdl/ld_ctrl.sv ====
`timescale 1ns/1ps

module ld_ctrl (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    input  logic valid_i,
    input  logic page_offset_match_i,
    input  logic dtlb_hit_i,
    input  logic dc_gnt_i,
    output logic pop_o,
    output logic translation_req_o,
    output logic dc_req_valid_o,
    output logic tag_valid_o,
    output logic kill_o,
    output logic meta_load_o,
    output logic flushing_o
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_PAGE_OFFSET,
        WAIT_GNT,
        SEND_TAG,
        ABORT,
        WAIT_TRANSLATION,
        WAIT_FLUSH
    } state_e;

    state_e state_q, state_d;

    // ------------------------------------------------------------------------
    // next state and outputs
    // ------------------------------------------------------------------------
    always_comb begin
        state_d           = state_q;
        pop_o             = 1'b0;
        translation_req_o = 1'b0;
        dc_req_valid_o    = 1'b0;
        tag_valid_o       = 1'b0;
        kill_o            = 1'b0;

        case (state_q)
            // nothing outstanding, a new load is picked up below
            IDLE: begin
                state_d = IDLE;
            end
            // the stalled load goes out once the store buffer no longer
            // holds a store to the same page offset
            WAIT_PAGE_OFFSET: begin
                if (!page_offset_match_i) begin
                    state_d = WAIT_GNT;
                end
            end
            // keep both the translation and the cache request up
            // the grant is resolved in the shared block further down
            WAIT_GNT: begin
                translation_req_o = 1'b1;
                dc_req_valid_o    = 1'b1;
            end
            // the tag is known to be valid here, the cache answers in this cycle
            SEND_TAG: begin
                tag_valid_o = 1'b1;
                state_d     = IDLE;
            end
            // TLB miss after the grant, so free the cache again and let the
            // page table walker get through
            ABORT: begin
                kill_o      = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = WAIT_TRANSLATION;
            end
            // hold the translation request until the walk has filled the TLB
            WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = WAIT_GNT;
                end
            end
            // kill whatever the cache may still have in flight
            WAIT_FLUSH: begin
                kill_o      = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // a new load can start when idle and also in the tag cycle of the
        // previous one, which keeps two loads in flight
        if ((state_q == IDLE || state_q == SEND_TAG) && valid_i) begin
            // translation starts right away, even if a store hazard stalls us
            translation_req_o = 1'b1;
            if (page_offset_match_i) begin
                state_d = WAIT_PAGE_OFFSET;
            end else begin
                dc_req_valid_o = 1'b1;
            end
        end

        // grant handling for every cycle in which a request is presented
        if (dc_req_valid_o) begin
            if (!dc_gnt_i) begin
                state_d = WAIT_GNT;
            end else if (dtlb_hit_i) begin
                // granted with a valid translation, tag follows next cycle
                pop_o   = 1'b1;
                state_d = SEND_TAG;
            end else begin
                state_d = ABORT;
            end
        end

        // a flush overrides everything else
        if (flush_i) begin
            state_d = WAIT_FLUSH;
        end
    end

    // the metadata of a load is kept exactly when it leaves the issue side
    assign meta_load_o = pop_o;
    assign flushing_o  = (state_q == WAIT_FLUSH);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== hdl/ld_req_format.sv ====
`timescale 1ns/1ps

module ld_req_format
    import lsu_pkg::*, dcache_pkg::*;
(
    input  ld_req_t                  req_i,
    input  logic [PLEN-1:0]          paddr_i,
    output dc_req_t                  dc_req_o,
    output logic [TAG_W-1:0]         tag_o,
    output logic [PAGE_OFFSET_W-1:0] page_offset_o
);

    dc_size_e            size;
    logic [DC_BE_W-1:0]  be_mask;

    // ------------------------------------------------------------------------
    // transfer size and byte enables
    // ------------------------------------------------------------------------

    // the size follows from the operator alone, the sign only matters
    // on the way back
    always_comb begin
        case (req_i.op)
            LB, LBU: size = BYTE;
            LH, LHU: size = HALF;
            LW, LWU: size = WORD;
            default: size = DWORD;
        endcase
    end

    // one enable per byte of the access, starting at bit 0
    always_comb begin
        case (size)
            BYTE:    be_mask = 8'h01;
            HALF:    be_mask = 8'h03;
            WORD:    be_mask = 8'h0f;
            default: be_mask = 8'hff;
        endcase
    end

    // loads are naturally aligned, so the shifted mask never leaves the word
    assign dc_req_o.be   = be_mask << req_i.vaddr[2:0];
    assign dc_req_o.size = size;

    // ------------------------------------------------------------------------
    // address slices
    // ------------------------------------------------------------------------

    // index and page offset are both the untranslated low address bits
    assign dc_req_o.index = req_i.vaddr[DC_INDEX_W-1:0];
    assign page_offset_o  = req_i.vaddr[PAGE_OFFSET_W-1:0];

    // the tag comes from the translation of this cycle and is sent one
    // cycle later by the cache port
    assign tag_o = paddr_i[PLEN-1:PAGE_OFFSET_W];

endmodule

// ==== hdl/ld_retire.sv ====
`timescale 1ns/1ps

module ld_retire
    import lsu_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  meta_load_i,
    input  logic                  flushing_i,
    input  ld_req_t               req_i,
    input  logic                  dc_rvalid_i,
    input  logic [XLEN-1:0]       dc_rdata_i,
    output logic                  res_valid_o,
    output logic [TRANS_ID_W-1:0] res_trans_id_o,
    output logic [XLEN-1:0]       res_data_o
);

    ld_meta_t        meta_q;
    logic [XLEN-1:0] shifted;

    // ------------------------------------------------------------------------
    // metadata of the load in flight
    // ------------------------------------------------------------------------

    // written in the cycle the request leaves the issue side
    // the cache answers in the following tag cycle, so one entry is enough
    // even when the next load is accepted in that same tag cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            meta_q <= '0;
        end else if (meta_load_i) begin
            meta_q.trans_id <= req_i.trans_id;
            meta_q.offset   <= req_i.vaddr[2:0];
            meta_q.op       <= req_i.op;
        end
    end

    // ------------------------------------------------------------------------
    // alignment and extension
    // ------------------------------------------------------------------------

    // move the addressed byte to bit 0, the offset counts in bytes
    assign shifted = dc_rdata_i >> {meta_q.offset, 3'b000};

    // take the field by size and extend it by the operator
    always_comb begin
        case (meta_q.op)
            LB: begin
                res_data_o = {{56{shifted[7]}}, shifted[7:0]};
            end
            LBU: begin
                res_data_o = {56'h0, shifted[7:0]};
            end
            LH: begin
                res_data_o = {{48{shifted[15]}}, shifted[15:0]};
            end
            LHU: begin
                res_data_o = {48'h0, shifted[15:0]};
            end
            LW: begin
                res_data_o = {{32{shifted[31]}}, shifted[31:0]};
            end
            LWU: begin
                res_data_o = {32'h0, shifted[31:0]};
            end
            // a double word is always at offset 0
            default: begin
                res_data_o = dc_rdata_i;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // result
    // ------------------------------------------------------------------------

    // data that arrives while the flush kill goes out belongs to a load
    // the core has already discarded
    assign res_valid_o    = dc_rvalid_i && !flushing_i;
    assign res_trans_id_o = meta_q.trans_id;

endmodule

// ==== hdl/load_unit.sv ====
`timescale 1ns/1ps

module load_unit
    import lsu_pkg::*, dcache_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    // issue side
    input  logic                     valid_i,
    input  ld_req_t                  req_i,
    output logic                     pop_o,
    // MMU
    output logic                     translation_req_o,
    output logic [XLEN-1:0]          vaddr_o,
    input  logic                     dtlb_hit_i,
    input  logic [PLEN-1:0]          paddr_i,
    // store buffer address check
    output logic [PAGE_OFFSET_W-1:0] page_offset_o,
    input  logic                     page_offset_match_i,
    // data cache
    output logic                     dc_req_valid_o,
    output dc_req_t                  dc_req_o,
    input  logic                     dc_gnt_i,
    output dc_tag_t                  dc_tag_o,
    input  logic                     dc_rvalid_i,
    input  logic [XLEN-1:0]          dc_rdata_i,
    // result toward writeback
    output logic                     res_valid_o,
    output logic [TRANS_ID_W-1:0]    res_trans_id_o,
    output logic [XLEN-1:0]          res_data_o
);

    logic meta_load;
    logic flushing;

    // the MMU translates the address of the load at the head of the issue side
    assign vaddr_o = req_i.vaddr;

    // ------------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------------
    ld_ctrl ctrl0 (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .valid_i             (valid_i),
        .page_offset_match_i (page_offset_match_i),
        .dtlb_hit_i          (dtlb_hit_i),
        .dc_gnt_i            (dc_gnt_i),
        .pop_o               (pop_o),
        .translation_req_o   (translation_req_o),
        .dc_req_valid_o      (dc_req_valid_o),
        .tag_valid_o         (dc_tag_o.tag_valid),
        .kill_o              (dc_tag_o.kill),
        .meta_load_o         (meta_load),
        .flushing_o          (flushing)
    );

    // ------------------------------------------------------------------------
    // request datapath
    // ------------------------------------------------------------------------
    ld_req_format fmt0 (
        .req_i         (req_i),
        .paddr_i       (paddr_i),
        .dc_req_o      (dc_req_o),
        .tag_o         (dc_tag_o.tag),
        .page_offset_o (page_offset_o)
    );

    // ------------------------------------------------------------------------
    // response datapath
    // ------------------------------------------------------------------------
    ld_retire ret0 (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .meta_load_i    (meta_load),
        .flushing_i     (flushing),
        .req_i          (req_i),
        .dc_rvalid_i    (dc_rvalid_i),
        .dc_rdata_i     (dc_rdata_i),
        .res_valid_o    (res_valid_o),
        .res_trans_id_o (res_trans_id_o),
        .res_data_o     (res_data_o)
    );

endmodule

// ==== hdl/lsu_pkg.sv ====
package lsu_pkg;

    // ------------------------------------------------------------------------
    // widths of the load path
    // ------------------------------------------------------------------------

    // data width and virtual address width of the core
    localparam int unsigned XLEN = 64;

    // physical address width as delivered by the MMU
    localparam int unsigned PLEN = 56;

    // the page offset is the part of the address that needs no translation
    localparam int unsigned PAGE_OFFSET_W = 12;

    // the physical tag is everything above the page offset
    localparam int unsigned TAG_W = PLEN - PAGE_OFFSET_W;

    // enough ids for the entries of the scoreboard
    localparam int unsigned TRANS_ID_W = 3;

    // ------------------------------------------------------------------------
    // load operators and request types
    // ------------------------------------------------------------------------

    // the U variants zero-extend, all others sign-extend
    // LD needs no extension on a 64-bit core
    typedef enum logic [2:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        LWU,
        LD
    } ld_op_e;

    // a load as it arrives from the issue side
    typedef struct packed {
        logic [XLEN-1:0]       vaddr;
        ld_op_e                op;
        logic [TRANS_ID_W-1:0] trans_id;
    } ld_req_t;

    // what has to survive until the data comes back from the cache
    // the offset picks the field inside the returned double word
    typedef struct packed {
        logic [TRANS_ID_W-1:0] trans_id;
        logic [2:0]            offset;
        ld_op_e                op;
    } ld_meta_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# Builds the load unit testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module load_unit_tb \
    -f all.f \
    -o sim_load_unit

if ! ./obj_dir/sim_load_unit > sim.log 2>&1; then
    cat sim.log
    echo "simulator exited with an error"
    exit 1
fi
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
